//--- model_arithmetic_pkg.sv
// Arithmetic package: IEEE-754 double word type, constants and field helper

package model_arithmetic_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////////////////////

  // Double precision layout
  localparam int DATA_WIDTH     = 64;
  localparam int EXPONENT_WIDTH = 11;
  localparam int MANTISSA_WIDTH = 52;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  // One IEEE-754 double, raw bits
  typedef logic [DATA_WIDTH-1:0] data_t;

  // Biased exponent field
  typedef logic [EXPONENT_WIDTH-1:0] exponent_t;

  ////////////////////////////////////////////////////////////////////////////
  // Constants
  ////////////////////////////////////////////////////////////////////////////

  // Positive zero
  localparam data_t ZERO_DATA = '0;

  // Exponent that marks infinity or NaN
  localparam exponent_t EXPONENT_ALL_ONES = '1;

  // Positive infinity: sign clear, mantissa clear
  localparam data_t INFINITY_DATA = {1'b0, EXPONENT_ALL_ONES, {MANTISSA_WIDTH{1'b0}}};

  // Extract exponent field from a double
  function automatic exponent_t exponent_field(input data_t data);
    return data[MANTISSA_WIDTH +: EXPONENT_WIDTH];
  endfunction

endpackage

//--- model_math_pkg.sv
// Math package: operation codes, function controller states and finiteness test

package model_math_pkg;

  // Word type and exponent helper
  import model_arithmetic_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  // Operation selected with START
  typedef enum logic [1:0] {
    OP_EXPONENTIAL = 2'd0,
    OP_LOGARITHM   = 2'd1,
    OP_SQUARE_ROOT = 2'd2
  } op_t;

  // Two-step controller of each function block
  //   STARTER_STATE waits for START and captures operand
  //   ENDER_STATE registers result and pulses READY
  typedef enum logic {
    STARTER_STATE = 1'b0,
    ENDER_STATE   = 1'b1
  } function_state_t;

  ////////////////////////////////////////////////////////////////////////////
  // Functions
  ////////////////////////////////////////////////////////////////////////////

  // True for infinity or NaN
  // Mantissa not looked at, both cases count as overflow
  function automatic logic is_not_finite(input data_t data);
    exponent_t exponent;
    exponent = exponent_field(data);
    return (exponent == EXPONENT_ALL_ONES);
  endfunction

endpackage

//--- model_scalar_exponentiator_function.sv
// Scalar exponential block: computes e to the power of a double, flags non-finite results

`timescale 1ns/1ns

module model_scalar_exponentiator_function
  import model_arithmetic_pkg::*;
  import model_math_pkg::*;
(
  // Global
  input  logic  CLK,
  input  logic  RST,

  // Control
  input  logic  START,
  output logic  READY,

  // Data
  input  data_t DATA_IN,
  output data_t DATA_OUT,
  output logic  OVERFLOW_OUT
);

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  // Controller state
  function_state_t state_int;

  // Captured operand bits
  data_t operand_int;

  // Real-number datapath
  real   operand_real;
  real   result_real;
  data_t result_int;

  ////////////////////////////////////////////////////////////////////////////
  // Body
  ////////////////////////////////////////////////////////////////////////////

  // Operand capture, only when idle
  always_ff @(posedge CLK) begin
    if (state_int == STARTER_STATE && START) begin
      operand_int <= DATA_IN;
    end
  end

  // Behavioral exponential
  always_comb begin
    operand_real = $bitstoreal(operand_int);
    result_real  = $exp(operand_real);
    result_int   = $realtobits(result_real);
  end

  // Controller
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      DATA_OUT     <= ZERO_DATA;
      OVERFLOW_OUT <= 1'b0;
      READY        <= 1'b0;
      state_int    <= STARTER_STATE;
    end else begin
      case (state_int)
        STARTER_STATE: begin
          // Drop READY one cycle after the pulse
          READY <= 1'b0;
          if (START) begin
            state_int <= ENDER_STATE;
          end
        end
        ENDER_STATE: begin
          // Result and flag together with READY
          DATA_OUT     <= result_int;
          OVERFLOW_OUT <= is_not_finite(result_int);
          READY        <= 1'b1;
          state_int    <= STARTER_STATE;
        end
        default: begin
          state_int <= STARTER_STATE;
        end
      endcase
    end
  end

endmodule

//--- model_scalar_logarithm_function.sv
// Scalar logarithm block: computes the natural logarithm of a double, flags non-finite results

`timescale 1ns/1ns

module model_scalar_logarithm_function
  import model_arithmetic_pkg::*;
  import model_math_pkg::*;
(
  // Global
  input  logic  CLK,
  input  logic  RST,

  // Control
  input  logic  START,
  output logic  READY,

  // Data
  input  data_t DATA_IN,
  output data_t DATA_OUT,
  output logic  OVERFLOW_OUT
);

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  // Controller state
  function_state_t state_int;

  // Captured operand bits
  data_t operand_int;

  // Real-number datapath
  real   operand_real;
  real   result_real;
  data_t result_int;

  ////////////////////////////////////////////////////////////////////////////
  // Body
  ////////////////////////////////////////////////////////////////////////////

  // Operand capture, only when idle
  always_ff @(posedge CLK) begin
    if (state_int == STARTER_STATE && START) begin
      operand_int <= DATA_IN;
    end
  end

  // Behavioral natural log
  // Zero gives -inf, negative gives NaN
  always_comb begin
    operand_real = $bitstoreal(operand_int);
    result_real  = $ln(operand_real);
    result_int   = $realtobits(result_real);
  end

  // Controller
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      DATA_OUT     <= ZERO_DATA;
      OVERFLOW_OUT <= 1'b0;
      READY        <= 1'b0;
      state_int    <= STARTER_STATE;
    end else begin
      case (state_int)
        STARTER_STATE: begin
          // Pulse ends here
          READY <= 1'b0;
          if (START) begin
            state_int <= ENDER_STATE;
          end
        end
        ENDER_STATE: begin
          // Both -inf and NaN raise the flag
          DATA_OUT     <= result_int;
          OVERFLOW_OUT <= is_not_finite(result_int);
          READY        <= 1'b1;
          state_int    <= STARTER_STATE;
        end
        default: begin
          state_int <= STARTER_STATE;
        end
      endcase
    end
  end

endmodule

//--- model_scalar_square_root_function.sv
// Scalar square root block: computes the square root of a double, flags non-finite results

`timescale 1ns/1ns

module model_scalar_square_root_function
  import model_arithmetic_pkg::*;
  import model_math_pkg::*;
(
  // Global
  input  logic  CLK,
  input  logic  RST,

  // Control
  input  logic  START,
  output logic  READY,

  // Data
  input  data_t DATA_IN,
  output data_t DATA_OUT,
  output logic  OVERFLOW_OUT
);

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  // Controller state
  function_state_t state_int;

  // Captured operand bits
  data_t operand_int;

  // Real-number datapath
  real   operand_real;
  real   result_real;
  data_t result_int;

  ////////////////////////////////////////////////////////////////////////////
  // Body
  ////////////////////////////////////////////////////////////////////////////

  // Operand capture, only when idle
  always_ff @(posedge CLK) begin
    if (state_int == STARTER_STATE && START) begin
      operand_int <= DATA_IN;
    end
  end

  // Behavioral square root
  // Negative operand gives NaN
  always_comb begin
    operand_real = $bitstoreal(operand_int);
    result_real  = $sqrt(operand_real);
    result_int   = $realtobits(result_real);
  end

  // Controller
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      DATA_OUT     <= ZERO_DATA;
      OVERFLOW_OUT <= 1'b0;
      READY        <= 1'b0;
      state_int    <= STARTER_STATE;
    end else begin
      case (state_int)
        STARTER_STATE: begin
          // Clear last pulse
          READY <= 1'b0;
          if (START) begin
            state_int <= ENDER_STATE;
          end
        end
        ENDER_STATE: begin
          // Register root and flag
          DATA_OUT     <= result_int;
          OVERFLOW_OUT <= is_not_finite(result_int);
          READY        <= 1'b1;
          state_int    <= STARTER_STATE;
        end
        default: begin
          state_int <= STARTER_STATE;
        end
      endcase
    end
  end

endmodule

//--- model_scalar_function_unit.sv
// Scalar function unit top: routes a request to exp, log or sqrt and selects the answer

`timescale 1ns/1ns

module model_scalar_function_unit
  import model_arithmetic_pkg::*;
  import model_math_pkg::*;
(
  // Global
  input  logic  CLK,
  input  logic  RST,

  // Control
  input  logic  START,
  input  op_t   OPERATION,

  // Data
  input  data_t DATA_IN,
  output logic  READY,
  output data_t DATA_OUT,
  output logic  OVERFLOW_OUT
);

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  // Request in flight, high for the cycle a block spends in ENDER_STATE
  logic busy_int;
  logic start_accepted_int;

  // Operation sampled with START, selects outputs later
  op_t operation_int;

  // Per-block handshake and results
  logic  exponentiator_start;
  logic  exponentiator_ready;
  data_t exponentiator_data_out;
  logic  exponentiator_overflow_out;

  logic  logarithm_start;
  logic  logarithm_ready;
  data_t logarithm_data_out;
  logic  logarithm_overflow_out;

  logic  square_root_start;
  logic  square_root_ready;
  data_t square_root_data_out;
  logic  square_root_overflow_out;

  ////////////////////////////////////////////////////////////////////////////
  // Request steering
  ////////////////////////////////////////////////////////////////////////////

  // A START in the busy cycle is dropped, same as in the blocks
  assign start_accepted_int = START & ~busy_int;

  assign exponentiator_start = start_accepted_int & (OPERATION == OP_EXPONENTIAL);
  assign logarithm_start     = start_accepted_int & (OPERATION == OP_LOGARITHM);
  assign square_root_start   = start_accepted_int & (OPERATION == OP_SQUARE_ROOT);

  // Busy tracker and operation latch
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy_int      <= 1'b0;
      operation_int <= OP_EXPONENTIAL;
    end else begin
      busy_int <= start_accepted_int;
      if (start_accepted_int) begin
        operation_int <= OPERATION;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Function blocks
  ////////////////////////////////////////////////////////////////////////////

  model_scalar_exponentiator_function exponentiator_function_i (
    .CLK          (CLK),
    .RST          (RST),
    .START        (exponentiator_start),
    .READY        (exponentiator_ready),
    .DATA_IN      (DATA_IN),
    .DATA_OUT     (exponentiator_data_out),
    .OVERFLOW_OUT (exponentiator_overflow_out)
  );

  model_scalar_logarithm_function logarithm_function_i (
    .CLK          (CLK),
    .RST          (RST),
    .START        (logarithm_start),
    .READY        (logarithm_ready),
    .DATA_IN      (DATA_IN),
    .DATA_OUT     (logarithm_data_out),
    .OVERFLOW_OUT (logarithm_overflow_out)
  );

  model_scalar_square_root_function square_root_function_i (
    .CLK          (CLK),
    .RST          (RST),
    .START        (square_root_start),
    .READY        (square_root_ready),
    .DATA_IN      (DATA_IN),
    .DATA_OUT     (square_root_data_out),
    .OVERFLOW_OUT (square_root_overflow_out)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Output selection
  ////////////////////////////////////////////////////////////////////////////

  // Only one block is ever active
  assign READY = exponentiator_ready | logarithm_ready | square_root_ready;

  // No output register, latency equals block latency
  always_comb begin
    case (operation_int)
      OP_EXPONENTIAL: begin
        DATA_OUT     = exponentiator_data_out;
        OVERFLOW_OUT = exponentiator_overflow_out;
      end
      OP_LOGARITHM: begin
        DATA_OUT     = logarithm_data_out;
        OVERFLOW_OUT = logarithm_overflow_out;
      end
      OP_SQUARE_ROOT: begin
        DATA_OUT     = square_root_data_out;
        OVERFLOW_OUT = square_root_overflow_out;
      end
      default: begin
        // Unused code 2'b11
        DATA_OUT     = ZERO_DATA;
        OVERFLOW_OUT = 1'b0;
      end
    endcase
  end

endmodule

//--- model_scalar_function_unit_properties.sv
// Scalar function unit assertions on READY pulse shape, latency and overflow flag

`timescale 1ns/1ns

module model_scalar_function_unit_properties
  import model_arithmetic_pkg::*;
  import model_math_pkg::*;
(
  input logic  CLK,
  input logic  RST,
  input logic  start_accepted,
  input logic  ready,
  input data_t data_out,
  input logic  overflow_out
);

  // Failed assertions so far
  int failure_count = 0;

  // One-cycle pulse only
  ready_single_pulse: assert property (@(posedge CLK) disable iff (RST)
    ready |=> !ready)
    else begin
      $error("READY stayed high for two cycles");
      failure_count = failure_count + 1;
    end

  // Low on the next edge and high on the one after
  ready_latency: assert property (@(posedge CLK) disable iff (RST)
    start_accepted |=> !ready ##1 ready)
    else begin
      $error("READY not two edges after an accepted START");
      failure_count = failure_count + 1;
    end

  // Flag means exponent all ones
  overflow_consistent: assert property (@(posedge CLK) disable iff (RST)
    ready |-> (overflow_out == is_not_finite(data_out)))
    else begin
      $error("OVERFLOW_OUT disagrees with DATA_OUT");
      failure_count = failure_count + 1;
    end

endmodule

bind model_scalar_function_unit model_scalar_function_unit_properties properties_i (
  .CLK            (CLK),
  .RST            (RST),
  .start_accepted (start_accepted_int),
  .ready          (READY),
  .data_out       (DATA_OUT),
  .overflow_out   (OVERFLOW_OUT)
);

//--- model_scalar_function_unit_tb.sv
// Scalar function unit testbench with random requests checked against a real-number model

`timescale 1ns/1ns

module model_scalar_function_unit_tb
  import model_arithmetic_pkg::*;
  import model_math_pkg::*;
();

  ////////////////////////////////////////////////////////////////////////////
  // Run parameters
  ////////////////////////////////////////////////////////////////////////////

  localparam int CLOCK_HALF    = 20;
  localparam int DRIVE_DELAY   = 2;
  localparam int RESET_CYCLES  = 10;
  localparam int RANDOM_COUNT  = 20;
  localparam int SPECIAL_COUNT = 4;
  localparam int MIXED_COUNT   = 30;

  // Request count over all tests
  localparam int REQUEST_TOTAL = 3 * RANDOM_COUNT + 3 * SPECIAL_COUNT + MIXED_COUNT;
  // Four times margin over five cycles per request
  localparam int CYCLE_LIMIT   = 4 * REQUEST_TOTAL * 5;

  logic   CLK;
  logic   RST;
  logic   START;
  op_t    OPERATION;
  data_t  DATA_IN;
  logic   READY;
  data_t  DATA_OUT;
  logic   OVERFLOW_OUT;

  integer seed;
  int     check_count;
  int     error_count;
  int     cycle_count = 0;

  model_scalar_function_unit model_scalar_function_unit_i (
    .CLK          (CLK),
    .RST          (RST),
    .START        (START),
    .OPERATION    (OPERATION),
    .DATA_IN      (DATA_IN),
    .READY        (READY),
    .DATA_OUT     (DATA_OUT),
    .OVERFLOW_OUT (OVERFLOW_OUT)
  );

  // 40 ns clock
  initial begin
    CLK = 1'b0;
    forever #CLOCK_HALF CLK = ~CLK;
  end

  // Run limit
  always @(posedge CLK) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: READY never arrived, run stopped after %0d cycles", CYCLE_LIMIT);
      $display("Some tests failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Model and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  // Uniform integer in 0 .. limit-1
  function automatic int random_below(input int limit);
    return $unsigned($random(seed)) % limit;
  endfunction

  // Expected result in real arithmetic
  function automatic data_t model_result(input op_t op, input data_t operand);
    real x;
    real y;
    x = $bitstoreal(operand);
    case (op)
      OP_EXPONENTIAL: y = $exp(x);
      OP_LOGARITHM:   y = $ln(x);
      default:        y = $sqrt(x);
    endcase
    return $realtobits(y);
  endfunction

  // NaN payload bits are not compared
  function automatic logic is_nan(input data_t data);
    return is_not_finite(data) && (data[MANTISSA_WIDTH-1:0] != '0);
  endfunction

  task automatic check_data(input string name, input data_t expected, input data_t actual);
    check_count = check_count + 1;
    if (actual !== expected) begin
      error_count = error_count + 1;
      $display("Mismatch at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_overflow(input string name, input logic expected, input logic actual);
    check_count = check_count + 1;
    if (actual !== expected) begin
      error_count = error_count + 1;
      $display("Mismatch at %0t ns: %s expected %b, actual %b", $time, name, expected, actual);
    end
  endtask

  task automatic check_ready(input logic expected, input logic actual);
    check_count = check_count + 1;
    if (actual !== expected) begin
      error_count = error_count + 1;
      $display("Mismatch at %0t ns: READY expected %b, actual %b", $time, expected, actual);
    end
  endtask

  // One request that returns at the falling edge where READY is seen
  task automatic issue_request(input op_t op, input data_t operand, input logic scramble);
    data_t expected;
    int    wait_cycles;
    expected = model_result(op, operand);
    @(posedge CLK);
    #DRIVE_DELAY;
    START     = 1'b1;
    OPERATION = op;
    DATA_IN   = operand;
    // Edge that samples START
    @(posedge CLK);
    #DRIVE_DELAY;
    START = 1'b0;
    if (scramble) begin
      OPERATION = op_t'(random_below(3));
      DATA_IN   = {$random(seed), $random(seed)};
    end
    @(negedge CLK);
    wait_cycles = 1;
    while (READY !== 1'b1) begin
      @(negedge CLK);
      wait_cycles = wait_cycles + 1;
    end
    // READY due on the second edge after the sampling edge
    check_count = check_count + 1;
    if (wait_cycles != 2) begin
      error_count = error_count + 1;
      $display("READY came %0d cycles after START at %0t ns instead of 2", wait_cycles, $time);
    end
    if (is_nan(expected)) begin
      check_count = check_count + 1;
      if (!is_nan(DATA_OUT)) begin
        error_count = error_count + 1;
        $display("DATA_OUT at %0t ns is %h and not a NaN as expected", $time, DATA_OUT);
      end
    end else begin
      check_data("DATA_OUT", expected, DATA_OUT);
    end
    check_overflow("OVERFLOW_OUT", is_not_finite(expected), OVERFLOW_OUT);
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("Test %s done with %0d errors", name, error_count - errors_before);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int  errors_before;
    int  index;
    int  assertion_failures;
    real operand;
    seed        = 32'hc8469dc1;
    check_count = 0;
    error_count = 0;
    RST         = 1'b1;
    START       = 1'b0;
    OPERATION   = OP_EXPONENTIAL;
    DATA_IN     = ZERO_DATA;
    repeat (RESET_CYCLES) @(posedge CLK);
    #DRIVE_DELAY;
    RST = 1'b0;

    // Reset values
    errors_before = error_count;
    @(negedge CLK);
    check_ready(1'b0, READY);
    check_overflow("OVERFLOW_OUT", 1'b0, OVERFLOW_OUT);
    check_data("DATA_OUT", ZERO_DATA, DATA_OUT);
    report_test("outputs after reset", errors_before);

    // Exponential finite for -50 .. 50 and overflowing above 710
    errors_before = error_count;
    for (index = 0; index < RANDOM_COUNT; index++) begin
      operand = (random_below(10001) - 5000) / 100.0;
      issue_request(OP_EXPONENTIAL, $realtobits(operand), 1'b0);
      check_overflow("OVERFLOW_OUT", 1'b0, OVERFLOW_OUT);
    end
    for (index = 0; index < SPECIAL_COUNT; index++) begin
      operand = 710.5 + random_below(1000) / 10.0;
      issue_request(OP_EXPONENTIAL, $realtobits(operand), 1'b0);
      check_data("DATA_OUT", INFINITY_DATA, DATA_OUT);
      check_overflow("OVERFLOW_OUT", 1'b1, OVERFLOW_OUT);
    end
    report_test("exponential", errors_before);

    // Logarithm of positives, of zero and of negatives
    errors_before = error_count;
    for (index = 0; index < RANDOM_COUNT; index++) begin
      operand = (random_below(1000000) + 1) / 1000.0;
      issue_request(OP_LOGARITHM, $realtobits(operand), 1'b0);
      check_overflow("OVERFLOW_OUT", 1'b0, OVERFLOW_OUT);
    end
    issue_request(OP_LOGARITHM, ZERO_DATA, 1'b0);
    check_data("DATA_OUT", {1'b1, EXPONENT_ALL_ONES, {MANTISSA_WIDTH{1'b0}}}, DATA_OUT);
    check_overflow("OVERFLOW_OUT", 1'b1, OVERFLOW_OUT);
    for (index = 1; index < SPECIAL_COUNT; index++) begin
      operand = -(random_below(1000) + 1) / 10.0;
      issue_request(OP_LOGARITHM, $realtobits(operand), 1'b0);
      check_overflow("OVERFLOW_OUT", 1'b1, OVERFLOW_OUT);
    end
    report_test("logarithm", errors_before);

    // Square root
    errors_before = error_count;
    for (index = 0; index < RANDOM_COUNT; index++) begin
      operand = random_below(1000000) / 100.0;
      issue_request(OP_SQUARE_ROOT, $realtobits(operand), 1'b0);
      check_overflow("OVERFLOW_OUT", 1'b0, OVERFLOW_OUT);
    end
    for (index = 0; index < SPECIAL_COUNT; index++) begin
      operand = -(random_below(1000) + 1) / 8.0;
      issue_request(OP_SQUARE_ROOT, $realtobits(operand), 1'b0);
      check_overflow("OVERFLOW_OUT", 1'b1, OVERFLOW_OUT);
    end
    report_test("square root", errors_before);

    // Mixed operations with OPERATION and DATA_IN scrambled after each START
    errors_before = error_count;
    for (index = 0; index < MIXED_COUNT; index++) begin
      operand = (random_below(4001) - 2000) / 100.0;
      issue_request(op_t'(random_below(3)), $realtobits(operand), 1'b1);
    end
    report_test("mixed sequence", errors_before);

    // Let pending assertions complete
    repeat (2) @(posedge CLK);
    #DRIVE_DELAY;
    assertion_failures = model_scalar_function_unit_i.properties_i.failure_count;

    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             check_count, error_count, assertion_failures);
    if (error_count == 0 && assertion_failures == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- all.f
model_arithmetic_pkg.sv
model_math_pkg.sv
model_scalar_exponentiator_function.sv
model_scalar_logarithm_function.sv
model_scalar_square_root_function.sv
model_scalar_function_unit.sv
model_scalar_function_unit_properties.sv
model_scalar_function_unit_tb.sv

//--- Bender.yml
package:
  name: model_scalar_function_unit

sources:
  - files:
      - model_arithmetic_pkg.sv
      - model_math_pkg.sv
      - model_scalar_exponentiator_function.sv
      - model_scalar_logarithm_function.sv
      - model_scalar_square_root_function.sv
      - model_scalar_function_unit.sv
  - target: test
    files:
      - model_scalar_function_unit_properties.sv
      - model_scalar_function_unit_tb.sv
